// File: uart_bridge.f
src/uart_bridge_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/cmd_decode.sv
src/reg_execute.sv
src/result_encode.sv
src/uart_tx.sv
src/uart_bridge.sv
verification/uart_bridge_properties.sv
verification/uart_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f uart_bridge.f --top-module uart_bridge_tb -Mdir obj_dir
./obj_dir/Vuart_bridge_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "Run reported errors, see sim.log"
	exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
	echo "Run ended without a verdict, see sim.log"
	exit 1
fi

// File: verification/uart_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_tb;

	// One serial bit and one 8N1 frame in clocks
	localparam int bit_clks = uart_bridge_pkg::clks_per_tick * uart_bridge_pkg::ticks_per_bit;
	localparam int frame_clks = bit_clks * (uart_bridge_pkg::data_bits + 2);
	localparam int test_count = 21;
	// Three frames per command covers cmd, data and response
	localparam int timeout_cycles = test_count * 3 * frame_clks + 2000;

	logic clk;
	logic arst_n;
	logic rx;
	wire tx;

	// Command table
	logic [7:0] tbl_cmd [test_count];
	bit tbl_has [test_count];
	logic [7:0] tbl_data [test_count];
	logic [7:0] tbl_exp [test_count];
	int tbl_len;

	int pass_cnt;
	int fail_cnt;
	int cycle_cnt;

	uart_bridge uart_bridge_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.rx     (rx),
		.tx     (tx)
	);

	////////////////////////////////////////
	// Clock and run limit
	////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic add_entry(input logic [7:0] cmd, input bit has_data,
		input logic [7:0] data, input logic [7:0] exp);
		tbl_cmd[tbl_len] = cmd;
		tbl_has[tbl_len] = has_data;
		tbl_data[tbl_len] = data;
		tbl_exp[tbl_len] = exp;
		tbl_len++;
	endtask

	// Register plus data modulo 256
	function automatic logic [7:0] add_mod256(input logic [7:0] a, input logic [7:0] b);
		int sum;
		sum = int'(a) + int'(b);
		return 8'(sum % 256);
	endfunction

	// Start bit, 8 data bits LSB first and stop bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		@(posedge clk);
		#1;
		for (int i = 0; i < 10; i++)
		begin
			rx = frame[i];
			repeat (bit_clks) @(posedge clk);
			#1;
		end
	endtask

	// Sampled on the falling clock away from the DUT's edge
	task automatic receive_byte(output logic [7:0] b, output bit ok);
		int wait_cnt;
		ok = 1'b1;
		b = '0;
		wait_cnt = 0;
		@(negedge clk);
		while (tx !== 1'b0 && wait_cnt < 3 * frame_clks)
		begin
			@(negedge clk);
			wait_cnt++;
		end
		assert (tx === 1'b0)
		else
		begin
			$display("No start bit seen on tx");
			ok = 1'b0;
		end
		if (ok)
		begin
			// Middle of start bit
			repeat (bit_clks / 2) @(negedge clk);
			assert (tx == 1'b0)
			else
			begin
				$display("Start bit on tx went high before mid-bit");
				ok = 1'b0;
			end
			for (int i = 0; i < uart_bridge_pkg::data_bits; i++)
			begin
				repeat (bit_clks) @(negedge clk);
				b[i] = tx;
			end
			repeat (bit_clks) @(negedge clk);
			assert (tx == 1'b1)
			else
			begin
				$display("Stop bit on tx is low");
				ok = 1'b0;
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [7:0] rnd_a;
		logic [7:0] rnd_b;
		logic [7:0] rnd_c;
		logic [7:0] sum_ab;
		logic [7:0] rsp;
		bit frame_ok;
		bit test_ok;

		arst_n = 1'b0;
		rx = 1'b1;
		tbl_len = 0;
		pass_cnt = 0;
		fail_cnt = 0;

		// Seeding call also draws the first data byte
		rnd_a = 8'($urandom(32'h0382_27a1));
		rnd_b = 8'($urandom);
		rnd_c = 8'($urandom);
		sum_ab = add_mod256(rnd_a, rnd_b);

		// Reads after reset
		add_entry(8'h40, 1'b0, 8'h00, 8'h00);
		add_entry(8'h4F, 1'b0, 8'h00, 8'h00);
		// Two writes, then read both back
		add_entry(8'h03, 1'b1, 8'hA5, 8'hA5);
		add_entry(8'h04, 1'b1, 8'h5A, 8'h5A);
		add_entry(8'h43, 1'b0, 8'h00, 8'hA5);
		add_entry(8'h44, 1'b0, 8'h00, 8'h5A);
		// Random write and add on r7
		add_entry(8'h07, 1'b1, rnd_a, rnd_a);
		add_entry(8'h87, 1'b1, rnd_b, sum_ab);
		add_entry(8'h47, 1'b0, 8'h00, sum_ab);
		// F0 + 25 wraps to 15
		add_entry(8'h09, 1'b1, 8'hF0, 8'hF0);
		add_entry(8'h89, 1'b1, 8'h25, 8'h15);
		add_entry(8'h49, 1'b0, 8'h00, 8'h15);
		// Rejected commands leave registers alone
		add_entry(8'hC3, 1'b0, 8'h00, uart_bridge_pkg::err_code);
		add_entry(8'h43, 1'b0, 8'h00, 8'hA5);
		add_entry(8'h13, 1'b0, 8'h00, uart_bridge_pkg::err_code);
		add_entry(8'h43, 1'b0, 8'h00, 8'hA5);
		add_entry(8'h64, 1'b0, 8'h00, uart_bridge_pkg::err_code);
		add_entry(8'hA9, 1'b0, 8'h00, uart_bridge_pkg::err_code);
		add_entry(8'h49, 1'b0, 8'h00, 8'h15);
		// Normal traffic after errors
		add_entry(8'h80, 1'b1, rnd_c, rnd_c);
		add_entry(8'h40, 1'b0, 8'h00, rnd_c);

		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Line must stay at mark after reset
		test_ok = 1'b1;
		repeat (2 * bit_clks)
		begin
			@(negedge clk);
			assert (tx == 1'b1)
			else
			begin
				if (test_ok)
					$display("Fail tx expected 0x1 got 0x%0h after reset", tx);
				test_ok = 1'b0;
			end
		end
		$display("Idle line after reset: %s", test_ok ? "ok" : "FAILED");
		if (test_ok)
			pass_cnt++;
		else
			fail_cnt++;

		for (int i = 0; i < tbl_len; i++)
		begin
			test_ok = 1'b1;
			// Response may start during the last stop bit
			fork
				begin
					send_byte(tbl_cmd[i]);
					if (tbl_has[i])
						send_byte(tbl_data[i]);
				end
				receive_byte(rsp, frame_ok);
			join
			if (!frame_ok)
				test_ok = 1'b0;
			else
			begin
				assert (rsp == tbl_exp[i])
				else
				begin
					$display("Fail tx_byte expected 0x%02h got 0x%02h", tbl_exp[i], rsp);
					test_ok = 1'b0;
				end
			end
			$display("Test %0d cmd 0x%02h data 0x%02h response 0x%02h: %s",
				i, tbl_cmd[i], tbl_data[i], rsp, test_ok ? "ok" : "FAILED");
			if (test_ok)
				pass_cnt++;
			else
				fail_cnt++;
		end

		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/uart_bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bridge_properties (
	input wire clk,
	input wire arst_n,
	input wire cmd_req,
	input wire cmd_ack,
	input wire res_req,
	input wire res_ack,
	input wire tx_done,
	input wire tx
);

	////////////////////////////////////////
	// Four-phase handshakes
	////////////////////////////////////////

	// Decode holds its request until execute answers
	cmd_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_req && !cmd_ack |=> cmd_req)
		else $error("cmd_req dropped before cmd_ack rose");

	// Execute holds its request until result answers
	res_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
		res_req && !res_ack |=> res_req)
		else $error("res_req dropped before res_ack rose");

	// Ack only ever answers a pending request
	cmd_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(cmd_ack) |-> cmd_req)
		else $error("cmd_ack rose with cmd_req low");

	res_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(res_ack) |-> res_req)
		else $error("res_ack rose with res_req low");

	////////////////////////////////////////
	// Serial line
	////////////////////////////////////////

	// Idle transmitter keeps the line at mark
	tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
		tx_done |-> tx)
		else $error("tx low while tx_done high");

endmodule

bind uart_bridge uart_bridge_properties uart_bridge_properties_inst (
	.clk     (clk),
	.arst_n  (arst_n),
	.cmd_req (cmd_req),
	.cmd_ack (cmd_ack),
	.res_req (res_req),
	.res_ack (res_ack),
	.tx_done (tx_done),
	.tx      (tx)
);

`default_nettype wire

// File: src/uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_bridge (
	input wire clk,
	input wire arst_n,
	input wire rx,
	output logic tx
);

	logic tick;

	// Receiver to decode
	logic [7:0] rx_data;
	logic rx_valid;

	// Decode to execute
	logic [1:0] cmd_op;
	logic [3:0] cmd_addr;
	logic [7:0] cmd_data;
	logic cmd_req;
	logic cmd_ack;

	// Execute to result
	logic [7:0] res_data;
	logic res_req;
	logic res_ack;

	// Result to transmitter
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_done;

	////////////////////////////////////////
	// Datapath chain
	////////////////////////////////////////

	baud_tick_gen baud_tick_gen_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.tick   (tick)
	);

	uart_rx uart_rx_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.tick     (tick),
		.rx       (rx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	cmd_decode cmd_decode_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.cmd_op   (cmd_op),
		.cmd_addr (cmd_addr),
		.cmd_data (cmd_data),
		.cmd_req  (cmd_req),
		.cmd_ack  (cmd_ack)
	);

	reg_execute reg_execute_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.cmd_op   (cmd_op),
		.cmd_addr (cmd_addr),
		.cmd_data (cmd_data),
		.cmd_req  (cmd_req),
		.cmd_ack  (cmd_ack),
		.res_data (res_data),
		.res_req  (res_req),
		.res_ack  (res_ack)
	);

	result_encode result_encode_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.res_data (res_data),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.tx_data  (tx_data),
		.tx_start (tx_start),
		.tx_done  (tx_done)
	);

	uart_tx uart_tx_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.tick     (tick),
		.tx_data  (tx_data),
		.tx_start (tx_start),
		.tx_done  (tx_done),
		.tx       (tx)
	);

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire clk,
	input wire arst_n,
	input wire tick,
	input wire [7:0] tx_data,
	input wire tx_start,
	output logic tx_done,
	output logic tx
);

	typedef enum logic [2:0] {s_idle, s_start, s_wait, s_send, s_stop} state_t;

	state_t state;
	state_t next_state;
	logic [3:0] tick_cnt;
	logic [3:0] bit_idx;
	logic [7:0] shift_reg;
	logic bit_end;

	// Last tick of the current bit
	assign bit_end = tick && tick_cnt == 4'(uart_bridge_pkg::ticks_per_bit - 2);

	////////////////////////////////////////
	// State register and next state
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= s_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			s_idle:
				if (tx_start)
					next_state = s_start;
			s_start, s_send, s_stop:
				if (tick)
					next_state = s_wait;
			s_wait:
				if (bit_end)
				begin
					if (bit_idx < 4'(uart_bridge_pkg::data_bits))
						next_state = s_send;
					else if (bit_idx == 4'(uart_bridge_pkg::data_bits))
						next_state = s_stop;
					else
						next_state = s_idle;
				end
			default:
				next_state = s_idle;
		endcase
	end

	////////////////////////////////////////
	// Output registers
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tx <= 1'b1;
			tx_done <= 1'b1;
			tick_cnt <= '0;
			bit_idx <= '0;
		end
		else if (tick)
		begin
			case (state)
				// Start bit opens on a tick
				s_start:
				begin
					tx <= 1'b0;
					tx_done <= 1'b0;
					tick_cnt <= '0;
					bit_idx <= '0;
				end
				s_wait:
				begin
					tick_cnt <= tick_cnt + 4'd1;
					// End of stop bit
					if (bit_end && bit_idx > 4'(uart_bridge_pkg::data_bits))
						tx_done <= 1'b1;
				end
				s_send:
				begin
					tx <= shift_reg[0];
					bit_idx <= bit_idx + 4'd1;
					tick_cnt <= '0;
				end
				s_stop:
				begin
					tx <= 1'b1;
					bit_idx <= bit_idx + 4'd1;
					tick_cnt <= '0;
				end
				default:
					tx <= 1'b1;
			endcase
		end
	end

	// Byte loaded at start, LSB first out
	always_ff @(posedge clk)
	begin
		if (state == s_idle && tx_start)
			shift_reg <= tx_data;
		else if (state == s_send && tick)
			shift_reg <= {1'b0, shift_reg[7:1]};
	end

endmodule

`default_nettype wire

// File: src/result_encode.sv
`timescale 1ns/1ps
`default_nettype none

module result_encode (
	input wire clk,
	input wire arst_n,
	input wire [7:0] res_data,
	input wire res_req,
	output logic res_ack,
	output logic [7:0] tx_data,
	output logic tx_start,
	input wire tx_done
);

	typedef enum logic [1:0] {s_idle, s_wait_busy, s_wait_done, s_ack} state_t;

	state_t state;
	logic launch;

	// New result and transmitter free
	assign launch = (state == s_idle) && res_req && tx_done;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= s_idle;
			tx_start <= 1'b0;
			res_ack <= 1'b0;
		end
		else
		begin
			// Single clock start pulse
			tx_start <= launch;
			case (state)
				s_idle:
					if (launch)
						state <= s_wait_busy;
				// Transmitter has taken the byte
				s_wait_busy:
					if (!tx_done)
						state <= s_wait_done;
				// Stop bit finished
				s_wait_done:
					if (tx_done)
					begin
						res_ack <= 1'b1;
						state <= s_ack;
					end
				s_ack:
					if (!res_req)
					begin
						res_ack <= 1'b0;
						state <= s_idle;
					end
				default:
					state <= s_idle;
			endcase
		end
	end

	// Byte held for the whole frame
	always_ff @(posedge clk)
	begin
		if (launch)
			tx_data <= res_data;
	end

endmodule

`default_nettype wire

// File: src/reg_execute.sv
`timescale 1ns/1ps
`default_nettype none

module reg_execute (
	input wire clk,
	input wire arst_n,
	input wire [1:0] cmd_op,
	input wire [3:0] cmd_addr,
	input wire [7:0] cmd_data,
	input wire cmd_req,
	output logic cmd_ack,
	output logic [7:0] res_data,
	output logic res_req,
	input wire res_ack
);

	typedef enum logic [1:0] {s_idle, s_busy, s_release} state_t;

	state_t state;
	logic [7:0] regs [uart_bridge_pkg::reg_count];
	logic [7:0] cur_val;
	logic [7:0] sum_val;
	logic accept;

	always_comb
	begin
		cur_val = regs[cmd_addr];
		// 8-bit add wraps modulo 256
		sum_val = cur_val + cmd_data;
		// Previous result fully released first
		accept = (state == s_idle) && cmd_req && !cmd_ack;
	end

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < uart_bridge_pkg::reg_count; i++)
				regs[i] <= '0;
		end
		else if (accept)
		begin
			if (cmd_op == uart_bridge_pkg::op_write)
				regs[cmd_addr] <= cmd_data;
			else if (cmd_op == uart_bridge_pkg::op_add)
				regs[cmd_addr] <= sum_val;
		end
	end

	// Response byte per opcode
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			case (cmd_op)
				uart_bridge_pkg::op_write: res_data <= cmd_data;
				uart_bridge_pkg::op_read:  res_data <= cur_val;
				uart_bridge_pkg::op_add:   res_data <= sum_val;
				default:                   res_data <= uart_bridge_pkg::err_code;
			endcase
		end
	end

	////////////////////////////////////////
	// Both handshakes
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= s_idle;
			cmd_ack <= 1'b0;
			res_req <= 1'b0;
		end
		else
		begin
			// Ack follows decode's req down
			if (cmd_ack && !cmd_req)
				cmd_ack <= 1'b0;
			case (state)
				s_idle:
					if (accept)
					begin
						cmd_ack <= 1'b1;
						res_req <= 1'b1;
						state <= s_busy;
					end
				s_busy:
					if (res_ack)
					begin
						res_req <= 1'b0;
						state <= s_release;
					end
				s_release:
					if (!res_ack)
						state <= s_idle;
				default:
					state <= s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
	input wire clk,
	input wire arst_n,
	input wire [7:0] rx_data,
	input wire rx_valid,
	output logic [1:0] cmd_op,
	output logic [3:0] cmd_addr,
	output logic [7:0] cmd_data,
	output logic cmd_req,
	input wire cmd_ack
);

	typedef enum logic [1:0] {s_wait_cmd, s_wait_data, s_request, s_release} state_t;

	state_t state;
	logic [1:0] op_in;
	logic bad_in;

	// Classify the incoming byte as a command
	always_comb
	begin
		op_in = rx_data[7:6];
		// Reserved bits set, or opcode 11
		bad_in = (rx_data[5:4] != 2'b00) || (op_in == uart_bridge_pkg::op_bad);
	end

	////////////////////////////////////////
	// Frame assembly and request
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= s_wait_cmd;
			cmd_req <= 1'b0;
		end
		else
		begin
			case (state)
				s_wait_cmd:
					if (rx_valid)
					begin
						// Only a legal write or add carries data
						if (bad_in || op_in == uart_bridge_pkg::op_read)
						begin
							cmd_req <= 1'b1;
							state <= s_request;
						end
						else
							state <= s_wait_data;
					end
				s_wait_data:
					if (rx_valid)
					begin
						cmd_req <= 1'b1;
						state <= s_request;
					end
				// Bytes seen here are dropped
				s_request:
					if (cmd_ack)
					begin
						cmd_req <= 1'b0;
						state <= s_release;
					end
				s_release:
					if (!cmd_ack)
						state <= s_wait_cmd;
				default:
					state <= s_wait_cmd;
			endcase
		end
	end

	// Payload captured as the bytes arrive
	always_ff @(posedge clk)
	begin
		if (state == s_wait_cmd && rx_valid)
		begin
			cmd_op <= bad_in ? uart_bridge_pkg::op_bad : op_in;
			cmd_addr <= rx_data[3:0];
		end
		if (state == s_wait_data && rx_valid)
			cmd_data <= rx_data;
	end

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input wire clk,
	input wire arst_n,
	input wire tick,
	input wire rx,
	output logic [7:0] rx_data,
	output logic rx_valid
);

	typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} state_t;

	state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [3:0] tick_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_reg;

	////////////////////////////////////////
	// Input synchronizer
	////////////////////////////////////////

	// Line idles high, so reset to 1
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= s_idle;
			tick_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			// Strobe lasts one clock
			rx_valid <= 1'b0;
			if (tick)
			begin
				case (state)
					s_idle:
						// Falling edge seen
						if (!rx_sync)
						begin
							tick_cnt <= '0;
							state <= s_start;
						end
					s_start:
						// Middle of start bit, still low or a glitch
						if (tick_cnt == 4'(uart_bridge_pkg::ticks_per_bit / 2 - 1))
						begin
							tick_cnt <= '0;
							bit_idx <= '0;
							state <= rx_sync ? s_idle : s_data;
						end
						else
							tick_cnt <= tick_cnt + 4'd1;
					s_data:
						if (tick_cnt == 4'(uart_bridge_pkg::ticks_per_bit - 1))
						begin
							tick_cnt <= '0;
							bit_idx <= bit_idx + 3'd1;
							if (bit_idx == 3'(uart_bridge_pkg::data_bits - 1))
								state <= s_stop;
						end
						else
							tick_cnt <= tick_cnt + 4'd1;
					s_stop:
						if (tick_cnt == 4'(uart_bridge_pkg::ticks_per_bit - 1))
						begin
							// Low stop bit, drop the byte quietly
							rx_valid <= rx_sync;
							tick_cnt <= '0;
							state <= s_idle;
						end
						else
							tick_cnt <= tick_cnt + 4'd1;
					default:
						state <= s_idle;
				endcase
			end
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge clk)
	begin
		if (tick && state == s_data && tick_cnt == 4'(uart_bridge_pkg::ticks_per_bit - 1))
			shift_reg <= {rx_sync, shift_reg[7:1]};
		// Hand the byte over together with the strobe
		if (tick && state == s_stop && tick_cnt == 4'(uart_bridge_pkg::ticks_per_bit - 1))
			rx_data <= shift_reg;
	end

endmodule

`default_nettype wire

// File: src/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
	input wire clk,
	input wire arst_n,
	output logic tick
);

	// Free running divider, 2 bits cover clks_per_tick
	logic [1:0] div_cnt;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_cnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// Wrap and pulse once per period
			if (div_cnt == 2'(uart_bridge_pkg::clks_per_tick - 1))
			begin
				div_cnt <= '0;
				tick <= 1'b1;
			end
			else
			begin
				div_cnt <= div_cnt + 2'd1;
				tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/uart_bridge_pkg.sv
`default_nettype none

package uart_bridge_pkg;

	////////////////////////////////////////
	// Serial timing
	////////////////////////////////////////

	// Clocks between two oversampling ticks
	localparam int clks_per_tick = 4;

	// Oversampling ticks per serial bit
	localparam int ticks_per_bit = 16;

	// Payload bits per frame, 8N1
	localparam int data_bits = 8;

	////////////////////////////////////////
	// Register file and command set
	////////////////////////////////////////

	// Addressable registers, 4-bit address
	localparam int reg_count = 16;

	// Opcodes in bits 7..6 of the command byte
	localparam logic [1:0] op_write = 2'b00;
	localparam logic [1:0] op_read  = 2'b01;
	localparam logic [1:0] op_add   = 2'b10;
	localparam logic [1:0] op_bad   = 2'b11;

	// Response for any rejected command
	localparam logic [7:0] err_code = 8'hEE;

endpackage

`default_nettype wire
